/* Bender.yml */
package:
  name: rv32i_pipeline

sources:
  - files:
      - common/rv32i_types.sv
      - common/control_word_types.sv
      - verilog/control_unit.sv
      - verilog/alu.sv
      - verilog/regfile.sv
      - datapath/load_masking.sv
      - datapath/datapath.sv
      - verilog/cpu.sv
  - target: test
    files:
      - verification/cpu_tb.sv

/* build.f */
common/rv32i_types.sv
common/control_word_types.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/regfile.sv
datapath/load_masking.sv
datapath/datapath.sv
verilog/cpu.sv
verification/cpu_tb.sv

/* common/control_word_types.sv */
`default_nettype none

package control_word_types;

    // operand a of the alu
    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    // operand b of the alu
    typedef enum logic [1:0] {
        alumux2_i_imm   = 2'd0,
        alumux2_u_imm   = 2'd1,
        alumux2_s_imm   = 2'd2,
        alumux2_rs2_out = 2'd3
    } alumux2_sel_t;

    typedef enum logic [1:0] {
        regfilemux_alu_out = 2'd0,
        regfilemux_u_imm   = 2'd1,
        regfilemux_load    = 2'd2
    } regfilemux_sel_t;

    // all zero is a bubble
    typedef struct packed {
        rv32i_types::alu_ops aluop;
        alumux1_sel_t        alumux1_sel;
        alumux2_sel_t        alumux2_sel;
        regfilemux_sel_t     regfilemux_sel;
        logic                load_regfile;
        logic                mem_read;
        logic                mem_write;
        logic [2:0]          funct3; // load/store width
    } rv32i_control_word;

endpackage

`default_nettype wire

/* common/rv32i_types.sv */
`default_nettype none

package rv32i_types;

    typedef logic [31:0] rv32i_word;

    localparam rv32i_word reset_vector = 32'h0000_0000; // first fetch address

    // base opcodes handled by this core
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_auipc = 7'b0010111,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011,
        op_lui   = 7'b0110111
    } rv32i_opcode;

    // alu_add must stay at zero, a cleared control word is an add
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_ops;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3;

endpackage

`default_nettype wire

/* datapath/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  logic                   clk,
    input  logic                   reset,

    input  rv32i_types::rv32i_word inst_rdata,
    output rv32i_types::rv32i_word inst_addr,
    output logic                   inst_read,

    input  rv32i_types::rv32i_word data_rdata,
    output rv32i_types::rv32i_word data_addr,
    output rv32i_types::rv32i_word data_wdata,
    output logic [3:0]             data_mbe,
    output logic                   data_read,
    output logic                   data_write,

    output logic [4:0]             rs1,
    output logic [4:0]             rs2,
    output logic [4:0]             rd,
    output rv32i_types::rv32i_word rd_data,
    output logic                   load_regfile,
    input  rv32i_types::rv32i_word rs1_out,
    input  rv32i_types::rv32i_word rs2_out
);

    // IF
    rv32i_types::rv32i_word pc;
    logic fetch_en;

    // IF/ID and decode
    rv32i_types::rv32i_word ir;
    rv32i_types::rv32i_word pc_id;
    logic id_valid;
    control_word_types::rv32i_control_word ctrl_word;
    control_word_types::rv32i_control_word ctrl_id;
    rv32i_types::rv32i_word i_imm;
    rv32i_types::rv32i_word s_imm;
    rv32i_types::rv32i_word u_imm;
    logic [4:0] rd_id;

    // ID/EX
    control_word_types::rv32i_control_word ctrl_ex;
    rv32i_types::rv32i_word pc_ex;
    rv32i_types::rv32i_word rs1_data_ex;
    rv32i_types::rv32i_word rs2_data_ex;
    rv32i_types::rv32i_word i_imm_ex;
    rv32i_types::rv32i_word s_imm_ex;
    rv32i_types::rv32i_word u_imm_ex;
    logic [4:0] rd_ex;
    rv32i_types::rv32i_word alumux1_out;
    rv32i_types::rv32i_word alumux2_out;
    rv32i_types::rv32i_word alu_out;

    // EX/MEM
    control_word_types::rv32i_control_word ctrl_mem;
    rv32i_types::rv32i_word alu_out_mem;
    rv32i_types::rv32i_word rs2_data_mem;
    rv32i_types::rv32i_word u_imm_mem;
    logic [4:0] rd_mem;

    // MEM/WB
    control_word_types::rv32i_control_word ctrl_wb;
    rv32i_types::rv32i_word alu_out_wb;
    rv32i_types::rv32i_word u_imm_wb;
    rv32i_types::rv32i_word rdata_wb;
    logic [4:0] rd_wb;
    rv32i_types::rv32i_word load_value;

    assign inst_addr = pc;
    assign inst_read = fetch_en;

    // instruction fields
    assign rs1   = ir[19:15];
    assign rs2   = ir[24:20];
    assign rd_id = ir[11:7];
    assign i_imm = {{21{ir[31]}}, ir[30:20]};
    assign s_imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
    assign u_imm = {ir[31:12], 12'h000};

    control_unit control_unit_inst (
        .opcode    (rv32i_types::rv32i_opcode'(ir[6:0])),
        .funct3    (ir[14:12]),
        .funct7    (ir[31:25]),
        .ctrl_word (ctrl_word)
    );

    assign ctrl_id = id_valid ? ctrl_word : '0; // nothing fetched, push a bubble

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= rv32i_types::reset_vector;
            fetch_en <= 1'b0;
            id_valid <= 1'b0;
            ctrl_ex  <= '0;
            ctrl_mem <= '0;
            ctrl_wb  <= '0;
        end else begin
            fetch_en <= 1'b1;
            if (fetch_en) pc <= pc + 32'd4;
            id_valid <= fetch_en;
            ctrl_ex  <= ctrl_id;
            ctrl_mem <= ctrl_ex;
            ctrl_wb  <= ctrl_mem;
        end
    end

    // payload, follows the control words
    always_ff @(posedge clk) begin
        ir           <= inst_rdata;
        pc_id        <= pc;
        pc_ex        <= pc_id;
        rs1_data_ex  <= rs1_out;
        rs2_data_ex  <= rs2_out;
        i_imm_ex     <= i_imm;
        s_imm_ex     <= s_imm;
        u_imm_ex     <= u_imm;
        rd_ex        <= rd_id;
        alu_out_mem  <= alu_out;
        rs2_data_mem <= rs2_data_ex;
        u_imm_mem    <= u_imm_ex;
        rd_mem       <= rd_ex;
        alu_out_wb   <= alu_out_mem;
        u_imm_wb     <= u_imm_mem;
        rdata_wb     <= data_rdata; // same-cycle memory answer
        rd_wb        <= rd_mem;
    end

    // EX operand muxes
    always_comb begin
        unique case (ctrl_ex.alumux1_sel)
            control_word_types::alumux1_pc_out: alumux1_out = pc_ex;
            default:                            alumux1_out = rs1_data_ex;
        endcase

        unique case (ctrl_ex.alumux2_sel)
            control_word_types::alumux2_i_imm: alumux2_out = i_imm_ex;
            control_word_types::alumux2_u_imm: alumux2_out = u_imm_ex;
            control_word_types::alumux2_s_imm: alumux2_out = s_imm_ex;
            default:                           alumux2_out = rs2_data_ex;
        endcase
    end

    alu alu_inst (
        .aluop (ctrl_ex.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_out)
    );

    // MEM, store data replicated into every lane, mask picks the lanes
    assign data_addr  = alu_out_mem;
    assign data_read  = ctrl_mem.mem_read;
    assign data_write = ctrl_mem.mem_write;

    always_comb begin
        case (rv32i_types::store_funct3'(ctrl_mem.funct3))
            rv32i_types::sb: begin
                data_wdata = {4{rs2_data_mem[7:0]}};
                data_mbe   = 4'b0001 << alu_out_mem[1:0];
            end
            rv32i_types::sh: begin
                data_wdata = {2{rs2_data_mem[15:0]}};
                data_mbe   = 4'b0011 << alu_out_mem[1:0];
            end
            default: begin
                data_wdata = rs2_data_mem; // sw
                data_mbe   = 4'b1111;
            end
        endcase
    end

    load_masking load_masking_inst (
        .funct3     (ctrl_wb.funct3),
        .addr_low   (alu_out_wb[1:0]),
        .rdata      (rdata_wb),
        .load_value (load_value)
    );

    // WB
    always_comb begin
        unique case (ctrl_wb.regfilemux_sel)
            control_word_types::regfilemux_u_imm: rd_data = u_imm_wb;
            control_word_types::regfilemux_load:  rd_data = load_value;
            default:                              rd_data = alu_out_wb;
        endcase
    end

    assign rd           = rd_wb;
    assign load_regfile = ctrl_wb.load_regfile && (rd_wb != 5'd0); // x0 writes dropped

endmodule

`default_nettype wire

/* datapath/load_masking.sv */
`timescale 1ns/1ns
`default_nettype none

module load_masking (
    input  logic [2:0]             funct3,
    input  logic [1:0]             addr_low,
    input  rv32i_types::rv32i_word rdata,
    output rv32i_types::rv32i_word load_value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    always_comb begin
        case (addr_low)
            2'd0:    byte_sel = rdata[7:0];
            2'd1:    byte_sel = rdata[15:8];
            2'd2:    byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    assign half_sel = addr_low[1] ? rdata[31:16] : rdata[15:0]; // halfwords are aligned

    always_comb begin
        case (rv32i_types::load_funct3'(funct3))
            rv32i_types::lb:  load_value = {{24{byte_sel[7]}}, byte_sel};
            rv32i_types::lbu: load_value = {24'b0, byte_sel};
            rv32i_types::lh:  load_value = {{16{half_sel[15]}}, half_sel};
            rv32i_types::lhu: load_value = {16'b0, half_sel};
            default:          load_value = rdata; // lw
        endcase
    end

endmodule

`default_nettype wire

/* verification/cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;

    typedef enum {kind_none, kind_wb, kind_store} result_kind_t;

    typedef struct {
        rv32i_types::rv32i_word instr;
        result_kind_t           kind;
        logic [4:0]             rd;
        rv32i_types::rv32i_word value; // writeback data or store lanes
        rv32i_types::rv32i_word addr;
        logic [3:0]             mbe;
    } entry_t;

    logic                   clk;
    logic                   reset;
    rv32i_types::rv32i_word inst_rdata;
    rv32i_types::rv32i_word data_rdata;
    rv32i_types::rv32i_word inst_addr;
    rv32i_types::rv32i_word data_addr;
    rv32i_types::rv32i_word data_wdata;
    logic                   inst_read;
    logic                   data_read;
    logic                   data_write;
    logic [3:0]             data_mbe;
    logic                   wb_valid;
    logic [4:0]             wb_rd;
    rv32i_types::rv32i_word wb_data;

    rv32i_types::rv32i_word imem [0:255];
    rv32i_types::rv32i_word dmem [0:63];
    rv32i_types::rv32i_word ref_mem [0:63]; // expected contents
    entry_t prog [$];
    entry_t wb_q [$];
    entry_t st_q [$];
    entry_t ld_q [$];
    integer seed;
    bit     prog_ready;

    cpu cpu_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_rdata (inst_rdata),
        .data_rdata (data_rdata),
        .inst_addr  (inst_addr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .inst_read  (inst_read),
        .data_read  (data_read),
        .data_write (data_write),
        .data_mbe   (data_mbe),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string what, input rv32i_types::rv32i_word got,
                              input rv32i_types::rv32i_word expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_mbe(input string what, input logic [3:0] got, input logic [3:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at %0t ns: %s is %b, expected %b",
                                        $time, what, got, expected));
        end
    endtask

    task automatic check_reg(input string what, input logic [4:0] got, input logic [4:0] expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("Fail at %0t ns: %s is x%0d, expected x%0d",
                                        $time, what, got, expected));
        end
    endtask

    // instruction encoders
    function automatic rv32i_types::rv32i_word enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                                     input logic [4:0] rs1, input logic [2:0] f3,
                                                     input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rv32i_types::op_reg};
    endfunction

    function automatic rv32i_types::rv32i_word enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                                     input logic [2:0] f3, input logic [4:0] rd,
                                                     input rv32i_types::rv32i_opcode opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic rv32i_types::rv32i_word enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                                     input rv32i_types::rv32i_opcode opc);
        return {imm, rd, opc};
    endfunction

    function automatic rv32i_types::rv32i_word lane_bits(input logic [3:0] mbe);
        return {{8{mbe[3]}}, {8{mbe[2]}}, {8{mbe[1]}}, {8{mbe[0]}}};
    endfunction

    // RV32I load semantics on the reference copy
    function automatic rv32i_types::rv32i_word expected_load(input rv32i_types::load_funct3 f3,
                                                             input rv32i_types::rv32i_word addr);
        rv32i_types::rv32i_word w;
        logic [7:0]             b;
        logic [15:0]            h;
        w = ref_mem[addr[7:2]];
        b = w[8 * addr[1:0] +: 8];
        h = w[16 * addr[1] +: 16];
        case (f3)
            rv32i_types::lb:  return rv32i_types::rv32i_word'($signed(b));
            rv32i_types::lbu: return {24'b0, b};
            rv32i_types::lh:  return rv32i_types::rv32i_word'($signed(h));
            rv32i_types::lhu: return {16'b0, h};
            default:          return w;
        endcase
    endfunction

    // every entry is followed by two nops so no result is read too early
    task automatic push_entry(input entry_t e);
        entry_t nop_e;
        nop_e = '{instr: 32'h0000_0013, kind: kind_none, rd: 5'd0, value: '0, addr: '0, mbe: '0};
        prog.push_back(e);
        if (e.kind == kind_wb) wb_q.push_back(e);
        if (e.kind == kind_store) st_q.push_back(e);
        prog.push_back(nop_e);
        prog.push_back(nop_e);
    endtask

    task automatic add_wb(input rv32i_types::rv32i_word instr, input logic [4:0] rd,
                          input rv32i_types::rv32i_word value);
        push_entry('{instr: instr, kind: kind_wb, rd: rd, value: value, addr: '0, mbe: '0});
    endtask

    task automatic add_load(input rv32i_types::load_funct3 f3, input logic [4:0] rd,
                            input rv32i_types::rv32i_word addr);
        entry_t e;
        e = '{instr: enc_i(addr[11:0], 5'd0, f3, rd, rv32i_types::op_load), kind: kind_wb,
              rd: rd, value: expected_load(f3, addr), addr: addr, mbe: '0};
        push_entry(e);
        ld_q.push_back(e);
    endtask

    // stores x27 with x0 as base and merges the ref copy by lanes
    task automatic add_store(input rv32i_types::store_funct3 f3, input rv32i_types::rv32i_word addr,
                             input logic [3:0] mbe, input rv32i_types::rv32i_word lanes);
        rv32i_types::rv32i_word instr;
        instr = {addr[11:5], 5'd27, 5'd0, f3, addr[4:0], rv32i_types::op_store};
        push_entry('{instr: instr, kind: kind_store, rd: 5'd0, value: lanes, addr: addr, mbe: mbe});
        ref_mem[addr[7:2]] = (ref_mem[addr[7:2]] & ~lane_bits(mbe)) | (lanes & lane_bits(mbe));
    endtask

    task automatic build_program();
        rv32i_types::rv32i_word pc_now;
        add_wb(enc_i(12'h123, 5'd0, 3'b000, 5'd1, rv32i_types::op_imm), 5'd1, 32'h0000_0123);
        add_wb(enc_i(12'hffb, 5'd0, 3'b000, 5'd2, rv32i_types::op_imm), 5'd2, 32'hffff_fffb);
        add_wb(enc_u(20'h80000, 5'd3, rv32i_types::op_lui), 5'd3, 32'h8000_0000);
        add_wb(enc_i(12'h007, 5'd0, 3'b000, 5'd4, rv32i_types::op_imm), 5'd4, 32'h0000_0007);
        add_wb(enc_u(20'ha1b2c, 5'd27, rv32i_types::op_lui), 5'd27, 32'ha1b2_c000);
        add_wb(enc_i(12'h3d4, 5'd27, 3'b000, 5'd27, rv32i_types::op_imm), 5'd27, 32'ha1b2_c3d4);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd5), 5'd5, 32'h0000_011e); // add
        add_wb(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd6), 5'd6, 32'h0000_0128); // sub
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), 5'd7, 32'h0000_0123);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd8), 5'd8, 32'hffff_fffb);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd9), 5'd9, 32'hffff_fed8);
        add_wb(enc_r(7'h00, 5'd4, 5'd1, 3'b001, 5'd10), 5'd10, 32'h0000_9180);
        add_wb(enc_r(7'h00, 5'd4, 5'd3, 3'b101, 5'd11), 5'd11, 32'h0100_0000); // srl
        add_wb(enc_r(7'h20, 5'd4, 5'd3, 3'b101, 5'd12), 5'd12, 32'hff00_0000); // sra
        add_wb(enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd13), 5'd13, 32'd1);
        add_wb(enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd14), 5'd14, 32'd0);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd15), 5'd15, 32'd1);
        add_wb(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd16), 5'd16, 32'd0);
        add_wb(enc_i(12'h0f0, 5'd1, 3'b100, 5'd17, rv32i_types::op_imm), 5'd17, 32'h0000_01d3);
        add_wb(enc_i(12'hf00, 5'd1, 3'b110, 5'd18, rv32i_types::op_imm), 5'd18, 32'hffff_ff23);
        add_wb(enc_i(12'h0ff, 5'd2, 3'b111, 5'd19, rv32i_types::op_imm), 5'd19, 32'h0000_00fb);
        add_wb(enc_i(12'hffc, 5'd2, 3'b010, 5'd20, rv32i_types::op_imm), 5'd20, 32'd1);
        add_wb(enc_i(12'hfff, 5'd1, 3'b011, 5'd21, rv32i_types::op_imm), 5'd21, 32'd1);
        add_wb(enc_i(12'h004, 5'd1, 3'b001, 5'd22, rv32i_types::op_imm), 5'd22, 32'h0000_1230);
        add_wb(enc_i(12'h01f, 5'd3, 3'b101, 5'd23, rv32i_types::op_imm), 5'd23, 32'd1);
        add_wb(enc_i(12'h404, 5'd3, 3'b101, 5'd24, rv32i_types::op_imm), 5'd24, 32'hf800_0000);
        pc_now = rv32i_types::reset_vector + 4 * prog.size();
        add_wb(enc_u(20'h12345, 5'd25, rv32i_types::op_auipc), 5'd25, pc_now + 32'h1234_5000);
        push_entry('{instr: enc_i(12'h005, 5'd1, 3'b000, 5'd0, rv32i_types::op_imm),
                     kind: kind_none, rd: 5'd0, value: '0, addr: '0, mbe: '0}); // x0 stays zero
        add_wb(enc_r(7'h00, 5'd4, 5'd0, 3'b000, 5'd26), 5'd26, 32'h0000_0007);
        add_store(rv32i_types::sw, 32'h40, 4'b1111, 32'ha1b2_c3d4);
        add_store(rv32i_types::sb, 32'h45, 4'b0010, 32'h0000_d400);
        add_store(rv32i_types::sb, 32'h4b, 4'b1000, 32'hd400_0000);
        add_store(rv32i_types::sh, 32'h4e, 4'b1100, 32'hc3d4_0000);
        add_store(rv32i_types::sh, 32'h50, 4'b0011, 32'h0000_c3d4);
        add_load(rv32i_types::lw, 5'd28, 32'h60);
        for (int k = 0; k < 4; k++) begin
            add_load(rv32i_types::lb, 5'd28, 32'h64 + k);
            add_load(rv32i_types::lbu, 5'd28, 32'h68 + k);
        end
        for (int k = 0; k < 2; k++) begin
            add_load(rv32i_types::lh, 5'd28, 32'h6c + 2 * k);
            add_load(rv32i_types::lhu, 5'd28, 32'h70 + 2 * k);
        end
        add_load(rv32i_types::lw, 5'd29, 32'h40); // read back merged words
        add_load(rv32i_types::lw, 5'd29, 32'h44);
        add_load(rv32i_types::lbu, 5'd29, 32'h45);
        add_load(rv32i_types::lw, 5'd29, 32'h48);
        add_load(rv32i_types::lb, 5'd29, 32'h4b);
        add_load(rv32i_types::lh, 5'd29, 32'h4e);
        add_load(rv32i_types::lw, 5'd29, 32'h4c);
        add_load(rv32i_types::lhu, 5'd29, 32'h50);
        add_load(rv32i_types::lw, 5'd29, 32'h50);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memories answer in the same cycle and write at the end of it
    initial begin
        inst_rdata = '0;
        data_rdata = '0;
        forever begin
            @(negedge clk);
            if ((data_read || data_write) && (data_addr[31:8] != 24'd0)) begin
                stop_with_failure("Data access outside the modeled data memory");
            end
            if (data_write) begin
                for (int b = 0; b < 4; b++) begin
                    if (data_mbe[b]) dmem[data_addr[7:2]][8 * b +: 8] = data_wdata[8 * b +: 8];
                end
            end
            inst_rdata = imem[inst_addr[9:2]];
            data_rdata = data_read ? dmem[data_addr[7:2]] : 'x;
        end
    end

    always @(negedge clk) begin : monitor
        entry_t e;
        if (wb_valid) begin
            if (wb_q.size() == 0) stop_with_failure("A writeback appeared that was not expected");
            e = wb_q.pop_front();
            check_reg("wb_rd", wb_rd, e.rd);
            check_word("wb_data", wb_data, e.value);
        end
        if (data_write) begin
            if (st_q.size() == 0) stop_with_failure("A store appeared that was not expected");
            e = st_q.pop_front();
            check_word("data_addr", data_addr, e.addr);
            check_mbe("data_mbe", data_mbe, e.mbe);
            check_word("data_wdata lanes", data_wdata & lane_bits(e.mbe), e.value);
        end
        if (data_read) begin
            if (ld_q.size() == 0) stop_with_failure("A load appeared that was not expected");
            e = ld_q.pop_front();
            check_word("load data_addr", data_addr, e.addr);
        end
    end

    initial begin
        wait (prog_ready);
        #((prog.size() + 10) * 100);
        stop_with_failure("Timeout: the program did not complete in the allowed time");
    end

    initial begin
        reset = 1'b1;
        seed = 32'heb15;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $random(seed);
            ref_mem[i] = dmem[i];
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, rv32i_types::op_imm); // nop per address
        end
        build_program();
        for (int i = 0; i < prog.size(); i++) imem[i] = prog[i].instr;
        prog_ready = 1'b1;
        repeat (3) begin
            @(negedge clk);
            if (inst_read || data_read || data_write || wb_valid) begin
                stop_with_failure("A strobe was active while reset was held");
            end
        end
        reset = 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(negedge clk);
            if (!inst_read) stop_with_failure("inst_read was low after reset");
            check_word("inst_addr", inst_addr, rv32i_types::reset_vector + 4 * i);
        end
        while ((wb_q.size() != 0) || (st_q.size() != 0) || (ld_q.size() != 0)) @(negedge clk);
        repeat (3) @(negedge clk); // stray strobes would still show
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv32i_types::alu_ops    aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0]; // only the low five bits count
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (aluop)
            rv32i_types::alu_add:  f = a + b;
            rv32i_types::alu_sub:  f = a - b;
            rv32i_types::alu_sll:  f = a << shamt;
            rv32i_types::alu_slt:  f = {31'b0, lt_signed};
            rv32i_types::alu_sltu: f = {31'b0, lt_unsigned};
            rv32i_types::alu_xor:  f = a ^ b;
            rv32i_types::alu_srl:  f = a >> shamt;
            rv32i_types::alu_sra:  f = rv32i_types::rv32i_word'($signed(a) >>> shamt);
            rv32i_types::alu_or:   f = a | b;
            rv32i_types::alu_and:  f = a & b;
            default:               f = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  rv32i_types::rv32i_opcode              opcode,
    input  logic [2:0]                            funct3,
    input  logic [6:0]                            funct7,
    output control_word_types::rv32i_control_word ctrl_word
);

    logic alt_op; // sub / sra

    // shared by register and immediate forms
    function automatic rv32i_types::alu_ops arith_op(input logic [2:0] f3, input logic alt);
        rv32i_types::alu_ops result;
        case (f3)
            3'b000:  result = alt ? rv32i_types::alu_sub : rv32i_types::alu_add;
            3'b001:  result = rv32i_types::alu_sll;
            3'b010:  result = rv32i_types::alu_slt;
            3'b011:  result = rv32i_types::alu_sltu;
            3'b100:  result = rv32i_types::alu_xor;
            3'b101:  result = alt ? rv32i_types::alu_sra : rv32i_types::alu_srl;
            3'b110:  result = rv32i_types::alu_or;
            default: result = rv32i_types::alu_and;
        endcase
        return result;
    endfunction

    // addi has no subtract, only srai looks at funct7
    assign alt_op = funct7[5] && ((opcode == rv32i_types::op_reg) || (funct3 == 3'b101));

    always_comb begin
        ctrl_word = '0;
        ctrl_word.funct3 = funct3;
        case (opcode)
            rv32i_types::op_reg: begin
                ctrl_word.aluop = arith_op(funct3, alt_op);
                ctrl_word.alumux2_sel = control_word_types::alumux2_rs2_out;
                ctrl_word.load_regfile = 1'b1;
            end
            rv32i_types::op_imm: begin
                ctrl_word.aluop = arith_op(funct3, alt_op);
                ctrl_word.alumux2_sel = control_word_types::alumux2_i_imm;
                ctrl_word.load_regfile = 1'b1;
            end
            rv32i_types::op_lui: begin
                ctrl_word.regfilemux_sel = control_word_types::regfilemux_u_imm;
                ctrl_word.load_regfile = 1'b1;
            end
            rv32i_types::op_auipc: begin
                ctrl_word.alumux1_sel = control_word_types::alumux1_pc_out; // pc + u_imm
                ctrl_word.alumux2_sel = control_word_types::alumux2_u_imm;
                ctrl_word.load_regfile = 1'b1;
            end
            rv32i_types::op_load: begin
                ctrl_word.alumux2_sel = control_word_types::alumux2_i_imm; // rs1 + offset
                ctrl_word.regfilemux_sel = control_word_types::regfilemux_load;
                ctrl_word.load_regfile = 1'b1;
                ctrl_word.mem_read = 1'b1;
            end
            rv32i_types::op_store: begin
                ctrl_word.alumux2_sel = control_word_types::alumux2_s_imm;
                ctrl_word.mem_write = 1'b1;
            end
            default: begin
                ctrl_word = '0; // unknown opcode becomes a bubble
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32i_types::rv32i_word inst_rdata,
    input  rv32i_types::rv32i_word data_rdata,
    output rv32i_types::rv32i_word inst_addr,
    output rv32i_types::rv32i_word data_addr,
    output rv32i_types::rv32i_word data_wdata,
    output logic                   inst_read,
    output logic                   data_read,
    output logic                   data_write,
    output logic [3:0]             data_mbe,
    output logic                   wb_valid,
    output logic [4:0]             wb_rd,
    output rv32i_types::rv32i_word wb_data
);

    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [4:0]             rd;
    rv32i_types::rv32i_word rd_data;
    logic                   load_regfile;
    rv32i_types::rv32i_word rs1_out;
    rv32i_types::rv32i_word rs2_out;

    datapath datapath_inst (
        .clk          (clk),
        .reset        (reset),
        .inst_rdata   (inst_rdata),
        .inst_addr    (inst_addr),
        .inst_read    (inst_read),
        .data_rdata   (data_rdata),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_mbe     (data_mbe),
        .data_read    (data_read),
        .data_write   (data_write),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .rd_data      (rd_data),
        .load_regfile (load_regfile),
        .rs1_out      (rs1_out),
        .rs2_out      (rs2_out)
    );

    regfile regfile_inst (
        .clk          (clk),
        .reset        (reset),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd           (rd),
        .rd_data      (rd_data),
        .load_regfile (load_regfile),
        .rs1_out      (rs1_out),
        .rs2_out      (rs2_out)
    );

    // writeback port for observation
    assign wb_valid = load_regfile;
    assign wb_rd    = rd;
    assign wb_data  = rd_data;

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  logic [4:0]             rd,
    input  rv32i_types::rv32i_word rd_data,
    input  logic                   load_regfile,
    output rv32i_types::rv32i_word rs1_out,
    output rv32i_types::rv32i_word rs2_out
);

    rv32i_types::rv32i_word data [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                data[i] <= '0;
            end
        end else if (load_regfile && (rd != 5'd0)) begin
            data[rd] <= rd_data;
        end
    end

    // read ports see a write of the same cycle
    always_comb begin
        if (rs1 == 5'd0) rs1_out = '0;
        else if (load_regfile && (rd == rs1)) rs1_out = rd_data;
        else rs1_out = data[rs1];

        if (rs2 == 5'd0) rs2_out = '0;
        else if (load_regfile && (rd == rs2)) rs2_out = rd_data;
        else rs2_out = data[rs2];
    end

endmodule

`default_nettype wire
